//--- logic/drive_pkg.sv
/*
  Shared types for the disk-image track subsystem of a 1541/157x drive core.
  Half-track values 254 and 255 are reserved and never hold a real track.
  The block address layout is fixed by the SD host's image format.
*/

package drive_pkg;

	// Head position in half-tracks, even values are whole tracks
	typedef logic [7:0] half_track_t;

	// Stepper motor phase as driven by the drive logic
	typedef logic [1:0] step_phase_t;

	// Speed zone and format selector, placed in the block address
	typedef logic [1:0] density_t;

	// Control levels from the drive side, after synchronization
	typedef struct packed {
		// Toggles once for every track the drive wants written back
		logic     save_track;
		// Disk change, only the rising edge matters
		logic     change;
		density_t density;
	} drive_ctl_t;

	// Request levels and block address going to the SD host
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] lba;
	} sd_req_t;

	// Marks that no track image sits in the track buffer
	localparam half_track_t no_track = 8'd255;

endpackage

//--- logic/level_sync.sv
/*
  Two-flop synchronizer for slow levels from another clock domain.
  Each bit is synchronized on its own, so a multi-bit payload must only
  change when the receiver can tolerate one mixed sample.
*/

`timescale 1ns/10ps

module level_sync #(
	parameter type sync_type = logic
) (
	input  logic     clk,
	input  sync_type din,
	output sync_type dout
);

	// First stage may go metastable, it is never read outside this module
	sync_type meta;

	// Outputs settle within two cycles, so no reset is needed here
	always_ff @(posedge clk) begin
		meta <= din;
		dout <= meta;
	end

endmodule

//--- logic/head_stepper.sv
/*
  Follows the stepper phase sequence and keeps the head position in half-tracks.
  The phase must already be synchronized to clk and must change by at most one
  quarter turn between samples, or a step is missed.
  The position saturates at 0 and at max_half_track.
*/

`timescale 1ns/10ps

module head_stepper
	import drive_pkg::*;
#(
	parameter int max_half_track   = 83,
	parameter int start_half_track = 36
) (
	input  logic        clk,
	input  logic        reset_s,
	input  step_phase_t phase,
	output half_track_t half_track
);

	// Phase seen on the previous clock
	step_phase_t prev_phase;

	// Neighbouring phases of the previous one, wrapping modulo 4
	step_phase_t phase_up;
	step_phase_t phase_down;

	logic step_out;
	logic step_in;
	logic at_top;
	logic at_bottom;

	assign phase_up   = prev_phase + 2'd1;
	assign phase_down = prev_phase - 2'd1;

	// A jump of two phases is ambiguous and is ignored like no change
	assign step_out = (phase == phase_up);
	assign step_in  = (phase == phase_down);

	// End stops of the head carriage
	assign at_top    = (half_track >= half_track_t'(max_half_track));
	assign at_bottom = (half_track == '0);

	always_ff @(posedge clk) begin
		if (reset_s) begin
			half_track <= half_track_t'(start_half_track);
			// Whatever phase is applied at reset counts as the rest position
			prev_phase <= phase;
		end else begin
			prev_phase <= phase;
			if (step_out && !at_top) begin
				half_track <= half_track + 8'd1;
			end else if (step_in && !at_bottom) begin
				half_track <= half_track - 8'd1;
			end
		end
	end

endmodule

//--- logic/track_loader.sv
/*
  Loads the track image under the head from the SD host and saves it back.
  The host must answer each request with an ack of one or more cycles and
  must not raise ack while no request is pending.
  Inputs other than sd_ack must already be synchronized to clk.
*/

`timescale 1ns/10ps

module track_loader
	import drive_pkg::*;
(
	input  logic        clk,
	input  logic        reset_s,
	input  half_track_t half_track,
	input  drive_ctl_t  ctl,
	input  logic        sd_ack,
	output sd_req_t     sd_req,
	output logic        busy
);

	// Track currently held in the host's track buffer
	half_track_t cur_track;

	// Block address fields of the request in flight
	half_track_t req_track;
	density_t    req_density;

	logic rd;
	logic wr;

	// A read is wanted even if the position did not move
	logic update;
	// Kind of transfer in flight, used for the follow-up read
	logic saving;
	logic initing;

	// Previous samples for edge detection
	logic old_save;
	logic old_change;
	logic old_ack;

	logic change_rise;
	logic save_toggle;
	logic ack_fall;
	logic can_save;
	logic moved;
	logic idle;
	logic start_save;
	logic start_read;
	logic start_follow;

	assign change_rise = ctl.change & ~old_change;
	assign save_toggle = ctl.save_track ^ old_save;
	assign ack_fall    = old_ack & ~sd_ack;
	assign moved       = (half_track != cur_track);

	// Nothing is saved while the buffer holds no_track or the reserved 254
	assign can_save = ~&cur_track[7:1];

	// No new request may start while the host still shows ack
	assign idle = ~busy & ~sd_ack;

	// A save takes priority over a read when both are wanted
	assign start_save = idle & save_toggle & can_save;
	assign start_read = idle & ~start_save & (moved | update);

	// After a save or the first load, a move during the transfer is read at once
	assign start_follow = busy & ack_fall & (saving | initing) & moved;

	assign sd_req.rd  = rd;
	assign sd_req.wr  = wr;
	assign sd_req.lba = {20'd0, 1'b0, req_density, 1'b1, req_track};

	// Address fields are latched at request start and held for the host
	always_ff @(posedge clk) begin
		if (start_save) begin
			req_track   <= cur_track;
			req_density <= ctl.density;
		end else if (start_read || start_follow) begin
			req_track   <= half_track;
			req_density <= ctl.density;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_s) begin
			cur_track  <= no_track;
			busy       <= 1'b0;
			rd         <= 1'b0;
			wr         <= 1'b0;
			saving     <= 1'b0;
			initing    <= 1'b1;
			update     <= 1'b1;
			// Levels present at reset do not count as edges
			old_save   <= ctl.save_track;
			old_change <= ctl.change;
			old_ack    <= 1'b0;
		end else begin
			old_ack    <= sd_ack;
			old_change <= ctl.change;

			// Save toggles during a transfer are kept for the next idle cycle
			if (!busy) begin
				old_save <= ctl.save_track;
			end

			// The request drops on the edge after ack was sampled high
			if (sd_ack) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			if (start_save) begin
				wr     <= 1'b1;
				busy   <= 1'b1;
				saving <= 1'b1;
			end else if (start_read) begin
				rd        <= 1'b1;
				busy      <= 1'b1;
				cur_track <= half_track;
			end else if (busy && ack_fall) begin
				saving  <= 1'b0;
				initing <= 1'b0;
				if (start_follow) begin
					// busy stays high across the follow-up read
					rd        <= 1'b1;
					cur_track <= half_track;
				end else begin
					busy <= 1'b0;
				end
			end

			if (start_read || start_follow) begin
				update <= 1'b0;
			end
			// A disk change seen in the same cycle still forces another read
			if (change_rise) begin
				update <= 1'b1;
			end
		end
	end

endmodule

//--- logic/drive_track_top.sv
/*
  Track subsystem top level of the drive core.
  phase and ctl may come from another clock domain and are synchronized here.
  sd_ack and reset_s must already be synchronous to clk.
*/

`timescale 1ns/10ps

module drive_track_top
	import drive_pkg::*;
#(
	parameter int max_half_track   = 83,
	parameter int start_half_track = 36
) (
	input  logic        clk,
	input  logic        reset_s,
	input  step_phase_t phase,
	input  drive_ctl_t  ctl,
	input  logic        sd_ack,
	output sd_req_t     sd_req,
	output logic        busy
);

	// Drive-side levels after the synchronizers
	step_phase_t phase_s;
	drive_ctl_t  ctl_s;

	// Head position from the stepper
	half_track_t half_track;

	// Stepper phase from the drive CPU port
	level_sync #(
		.sync_type(step_phase_t)
	) i_phase_sync (
		.clk (clk),
		.din (phase),
		.dout(phase_s)
	);

	// Save, change and density levels travel together
	level_sync #(
		.sync_type(drive_ctl_t)
	) i_ctl_sync (
		.clk (clk),
		.din (ctl),
		.dout(ctl_s)
	);

	head_stepper #(
		.max_half_track  (max_half_track),
		.start_half_track(start_half_track)
	) i_stepper (
		.clk       (clk),
		.reset_s   (reset_s),
		.phase     (phase_s),
		.half_track(half_track)
	);

	// Issues the SD block reads and writes for the track buffer
	track_loader i_loader (
		.clk       (clk),
		.reset_s   (reset_s),
		.half_track(half_track),
		.ctl       (ctl_s),
		.sd_ack    (sd_ack),
		.sd_req    (sd_req),
		.busy      (busy)
	);

endmodule

//--- tests/tb_clock.sv
/*
  Clock and reset source for the testbench.
  Period is 100 ns, reset_s is held high over the first two rising edges.
*/

`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic reset_s
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset drops on a falling edge, away from the DUT's sampling edge
	initial begin
		reset_s = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_s <= 1'b0;
	end

endmodule

//--- tests/tb_checker.sv
/*
  Watches the SD requests of the track subsystem and compares each one with
  the request queued by the stimulus. Sampling is on the falling clock edge,
  so rd and wr are assumed to stay high for at least one full cycle.
*/

`timescale 1ns/10ps

module tb_checker
	import drive_pkg::*;
(
	input logic    clk,
	input logic    reset_s,
	input sd_req_t sd_req,
	input logic    busy
);

	// One expected request as queued by the stimulus
	typedef struct packed {
		logic        wr;
		logic [31:0] lba;
	} exp_req_t;

	// Cycles a new request may wait for its expected entry
	localparam int queue_timeout = 20;

	exp_req_t exp_q[$];

	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	// Falling edges of busy, the stimulus reads this around a save
	int busy_falls = 0;

	logic        old_rd;
	logic        old_wr;
	logic        old_busy;
	logic [31:0] held_lba;

	task automatic expect_req(input logic is_write, input logic [31:0] lba);
		exp_q.push_back({is_write, lba});
	endtask

	// A wrong value seen on the DUT
	task automatic report_mismatch(input string msg);
		errors++;
		test_errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	// Anything else that went wrong, such as a response that never came
	task automatic report_problem(input string msg);
		errors++;
		test_errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic check_true(input logic ok, input string msg);
		checks++;
		test_checks++;
		if (ok !== 1'b1) begin
			report_mismatch(msg);
		end
	endtask

	// Entries still queued here belong to requests the DUT never made
	task automatic end_test(input string name);
		exp_req_t dropped;
		while (exp_q.size() > 0) begin
			dropped = exp_q.pop_front();
			report_problem($sformatf("expected request with lba %h never arrived", dropped.lba));
		end
		$display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic print_totals();
		$display("Totals: %0d checks, %0d errors", checks, errors);
	endtask

	task automatic compare_request(input logic is_write, input logic [31:0] lba);
		exp_req_t want;
		int       n;
		n = 0;
		while (exp_q.size() == 0 && n < queue_timeout) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() == 0) begin
			report_problem($sformatf("a %s of lba %h came while no request was expected",
				is_write ? "write" : "read", lba));
		end else begin
			want = exp_q.pop_front();
			checks++;
			test_checks++;
			if (want.wr !== is_write) begin
				report_mismatch($sformatf("expected a %s of lba %h, got a %s of lba %h",
					want.wr ? "write" : "read", want.lba, is_write ? "write" : "read", lba));
			end else if (want.lba !== lba) begin
				report_mismatch($sformatf("%s lba expected %h, got %h",
					is_write ? "write" : "read", want.lba, lba));
			end
		end
	endtask

	always @(negedge clk) begin
		if (reset_s) begin
			old_rd   = 1'b0;
			old_wr   = 1'b0;
			old_busy = 1'b0;
		end else begin
			if (busy === 1'b0 && old_busy === 1'b1) begin
				busy_falls++;
			end
			if (sd_req.rd === 1'b1 && sd_req.wr === 1'b1) begin
				report_mismatch("rd and wr are high together");
			end
			// A rising request level starts a new transfer
			if ((sd_req.rd && !old_rd) || (sd_req.wr && !old_wr)) begin
				held_lba = sd_req.lba;
				compare_request(sd_req.wr, sd_req.lba);
			end else if ((sd_req.rd && old_rd) || (sd_req.wr && old_wr)) begin
				// The host may read lba at any time while the level holds
				if (sd_req.lba !== held_lba) begin
					report_mismatch($sformatf("lba moved from %h to %h during a request",
						held_lba, sd_req.lba));
				end
			end
			old_rd   = sd_req.rd;
			old_wr   = sd_req.wr;
			old_busy = busy;
		end
	end

endmodule

//--- tests/tb_drive_track.sv
/*
  Testbench for the drive track subsystem.
  An SD host model answers each request after a random delay and tb_checker
  compares every request with the one the stimulus expects.
  The head model assumes the DUT runs with the default 36 and 83 limits.
*/

`timescale 1ns/10ps

module tb_drive_track
	import drive_pkg::*;
();

	localparam int max_ht   = 83;
	localparam int start_ht = 36;
	// Cycles any wait on the DUT may take before it counts as lost
	localparam int wait_limit = 200;

	logic        clk;
	logic        reset_s;
	step_phase_t phase;
	drive_ctl_t  ctl;
	logic        sd_ack;
	sd_req_t     sd_req;
	logic        busy;

	// Head model that follows the stepper rule
	step_phase_t model_phase;
	half_track_t model_track;

	integer seed;
	int     wait_n;
	int     ack_n;
	int     falls;
	int     i;

	tb_clock i_clock (
		.clk    (clk),
		.reset_s(reset_s)
	);

	drive_track_top #(
		.max_half_track  (max_ht),
		.start_half_track(start_ht)
	) i_dut (
		.clk    (clk),
		.reset_s(reset_s),
		.phase  (phase),
		.ctl    (ctl),
		.sd_ack (sd_ack),
		.sd_req (sd_req),
		.busy   (busy)
	);

	tb_checker i_checker (
		.clk    (clk),
		.reset_s(reset_s),
		.sd_req (sd_req),
		.busy   (busy)
	);

	// Block address built field by field with bits 31 to 11 left at zero
	function automatic logic [31:0] expected_lba(input density_t dens, input half_track_t ht);
		logic [31:0] lba;
		lba        = 32'd0;
		lba[7:0]   = ht;
		lba[8]     = 1'b1;
		lba[10:9]  = dens;
		return lba;
	endfunction

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (busy !== level) begin
			i_checker.report_problem($sformatf("busy did not go %s within %0d cycles",
				level ? "high" : "low", wait_limit));
		end
	endtask

	// One extra edge lets the checker count the busy fall first
	task automatic run_transfer();
		wait_busy(1'b1);
		wait_busy(1'b0);
		@(negedge clk);
	endtask

	task automatic stay_idle(input int cycles);
		int   n;
		logic started;
		started = 1'b0;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (busy !== 1'b0) begin
				started = 1'b1;
			end
		end
		i_checker.check_true(!started, "a transfer started while none was expected");
	endtask

	// dir is +1 outward, -1 inward, 2 for an ambiguous jump
	task automatic step_head(input int dir);
		half_track_t next;
		next = model_track;
		if (dir == 1 && model_track < max_ht) begin
			next = model_track + 8'd1;
		end else if (dir == -1 && model_track > 0) begin
			next = model_track - 8'd1;
		end
		if (next != model_track) begin
			i_checker.expect_req(1'b0, expected_lba(ctl.density, next));
		end
		model_phase = model_phase + step_phase_t'(dir);
		phase       = model_phase;
		if (next != model_track) begin
			model_track = next;
			run_transfer();
		end else begin
			// Path from phase to request is 4 cycles, so 8 is plenty
			stay_idle(8);
		end
	endtask

	task automatic disk_change();
		i_checker.expect_req(1'b0, expected_lba(ctl.density, model_track));
		ctl.change = 1'b1;
		run_transfer();
		ctl.change = 1'b0;
	endtask

	// SD host model waits 1 to 6 cycles and then acks for 1 to 4 cycles
	initial begin
		seed   = 24;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset_s && (sd_req.rd || sd_req.wr)) begin
				wait_n = 1 + ({$random(seed)} % 6);
				ack_n  = 1 + ({$random(seed)} % 4);
				repeat (wait_n) @(negedge clk);
				sd_ack = 1'b1;
				repeat (ack_n) @(negedge clk);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin
		phase       = '0;
		ctl         = '0;
		model_phase = '0;
		model_track = half_track_t'(start_ht);

		@(negedge clk);
		i_checker.check_true(sd_req.rd === 1'b0 && sd_req.wr === 1'b0 && busy === 1'b0,
			"rd, wr or busy not low in reset");
		i_checker.expect_req(1'b0, expected_lba(ctl.density, model_track));
		run_transfer();
		i_checker.end_test("reset load");

		for (i = 0; i < 3; i++) begin
			step_head(1);
		end
		for (i = 0; i < 5; i++) begin
			step_head(-1);
		end
		step_head(2);
		step_head(1);
		step_head(2);
		step_head(-1);
		i_checker.end_test("stepping");

		// Run into both stops and read back the position with a disk change
		for (i = 0; i < start_ht + 2; i++) begin
			step_head(-1);
		end
		disk_change();
		for (i = 0; i < max_ht + 2; i++) begin
			step_head(1);
		end
		disk_change();
		i_checker.end_test("end stops");

		i_checker.expect_req(1'b1, expected_lba(ctl.density, model_track));
		ctl.save_track = ~ctl.save_track;
		run_transfer();
		// Head moves inward while the write is in flight
		falls = i_checker.busy_falls;
		i_checker.expect_req(1'b1, expected_lba(ctl.density, model_track));
		i_checker.expect_req(1'b0, expected_lba(ctl.density, model_track - 8'd1));
		ctl.save_track = ~ctl.save_track;
		model_phase    = model_phase - 2'd1;
		model_track    = model_track - 8'd1;
		phase          = model_phase;
		run_transfer();
		// The follow-up read is the last transfer and busy falls only once for the pair
		stay_idle(4);
		i_checker.check_true(i_checker.busy_falls == falls + 1,
			"busy fell between the write and the follow-up read");
		i_checker.end_test("save");

		disk_change();
		ctl.density = 2'd2;
		stay_idle(6);
		disk_change();
		i_checker.end_test("disk change");

		i_checker.print_totals();
		if (i_checker.errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
logic/drive_pkg.sv
logic/level_sync.sv
logic/head_stepper.sv
logic/track_loader.sv
logic/drive_track_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_drive_track.sv
